// File: rtl/buf_cfg_pkg.sv
`default_nettype none

package buf_cfg_pkg;

  // ****************************************
  // port and bank counts
  // ****************************************
  localparam int NUM_WR_PORTS = 4;
  localparam int NUM_BANKS    = 6;
  localparam int BANK_BITS    = 3;

  // rows per bank, each row holds one word
  localparam int NUM_ROWS     = 16;
  localparam int ROW_BITS     = 4;

  // ****************************************
  // word and address layout
  // ****************************************
  localparam int DATA_WIDTH   = 32;

  // address is {bank, row}
  localparam int ADDR_BITS    = BANK_BITS + ROW_BITS;

  // bank slice register plus collector register
  localparam int RD_LATENCY   = 2;

endpackage

`default_nettype wire

// File: rtl/buf_types_pkg.sv
`default_nettype none

package buf_types_pkg;

  // ****************************************
  // write side, one per port
  // ****************************************
  typedef struct packed {
    logic                                write;
    logic [buf_cfg_pkg::DATA_WIDTH-1:0]  din;
  } wr_req_t;

  // ****************************************
  // dispatcher to bank slice
  // ****************************************
  typedef struct packed {
    // read strobe and optional dequeue of the read row
    logic                                read;
    logic                                deq;
    logic [buf_cfg_pkg::ROW_BITS-1:0]    rd_row;
    // write goes to the row on top of the free stack
    logic                                write;
    logic [buf_cfg_pkg::DATA_WIDTH-1:0]  din;
  } bank_cmd_t;

  // ****************************************
  // bank slice to read collector
  // ****************************************
  typedef struct packed {
    logic                                vld;
    logic [buf_cfg_pkg::DATA_WIDTH-1:0]  data;
  } bank_rsp_t;

endpackage

`default_nettype wire

// File: rtl/bank_sram.sv
`timescale 1ns/1ps
`default_nettype none

// register file, one write port and one async read port
module bank_sram #(
  parameter type item_t = logic [31:0],
  parameter int  DEPTH  = 16
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  item_t                    wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output item_t                    rdata
);

  item_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // read sees the old value during a same-cycle write
  assign rdata = mem[raddr];

endmodule

`default_nettype wire

// File: rtl/bank_slice.sv
`timescale 1ns/1ps
`default_nettype none

module bank_slice (
  input  logic                                clk,
  input  logic                                rst,
  input  buf_types_pkg::bank_cmd_t            cmd,
  output logic                                has_free,
  output logic [buf_cfg_pkg::ROW_BITS-1:0]    free_row,
  output logic                                init_done,
  output buf_types_pkg::bank_rsp_t            rsp
);

  // sp counts entries, top of stack sits at sp-1
  logic [buf_cfg_pkg::ROW_BITS:0]       sp;
  logic [buf_cfg_pkg::ROW_BITS-1:0]     init_cnt;
  logic                                 push;
  logic                                 pop;
  logic                                 stk_we;
  logic [buf_cfg_pkg::ROW_BITS-1:0]     stk_waddr;
  logic [buf_cfg_pkg::ROW_BITS-1:0]     stk_wdata;
  logic [buf_cfg_pkg::ROW_BITS-1:0]     stk_raddr;
  logic [buf_cfg_pkg::DATA_WIDTH-1:0]   rd_data;

  assign pop  = cmd.write;
  assign push = cmd.read && cmd.deq && init_done;

  // ****************************************
  // free-row stack
  // ****************************************
  // init fills from the bottom with the highest row, so row 0 ends on top
  assign stk_we    = !init_done || push;
  assign stk_waddr = init_done ? sp[buf_cfg_pkg::ROW_BITS-1:0] : init_cnt;
  assign stk_wdata = init_done ? cmd.rd_row
                               : buf_cfg_pkg::ROW_BITS'(buf_cfg_pkg::NUM_ROWS - 1) - init_cnt;
  assign stk_raddr = sp[buf_cfg_pkg::ROW_BITS-1:0] - 1'b1;

  bank_sram #(
    .item_t (logic [buf_cfg_pkg::ROW_BITS-1:0]),
    .DEPTH  (buf_cfg_pkg::NUM_ROWS)
  ) u_stack (
    .clk   (clk),
    .we    (stk_we),
    .waddr (stk_waddr),
    .wdata (stk_wdata),
    .raddr (stk_raddr),
    .rdata (free_row)
  );

  assign has_free = (sp != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      sp        <= '0;
      init_cnt  <= '0;
      init_done <= 1'b0;
    end else if (!init_done) begin
      init_cnt <= init_cnt + 1'b1;
      if (init_cnt == buf_cfg_pkg::ROW_BITS'(buf_cfg_pkg::NUM_ROWS - 1)) begin
        init_done <= 1'b1;
        sp        <= (buf_cfg_pkg::ROW_BITS + 1)'(buf_cfg_pkg::NUM_ROWS);
      end
    end else if (push) begin
      sp <= sp + 1'b1;
    end else if (pop) begin
      sp <= sp - 1'b1;
    end
  end

  // ****************************************
  // data array and read register
  // ****************************************
  bank_sram #(
    .item_t (logic [buf_cfg_pkg::DATA_WIDTH-1:0]),
    .DEPTH  (buf_cfg_pkg::NUM_ROWS)
  ) u_data (
    .clk   (clk),
    .we    (cmd.write),
    .waddr (free_row),
    .wdata (cmd.din),
    .raddr (cmd.rd_row),
    .rdata (rd_data)
  );

  always_ff @(posedge clk) begin
    rsp.data <= rd_data;
    if (rst) begin
      rsp.vld <= 1'b0;
    end else begin
      rsp.vld <= cmd.read;
    end
  end

  // dispatcher must respect the stack state and the read bank rule
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    pop |-> sp != '0);
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    push |-> sp != (buf_cfg_pkg::ROW_BITS + 1)'(buf_cfg_pkg::NUM_ROWS));
  a_no_rd_wr: assert property (@(posedge clk) disable iff (rst)
    !(cmd.read && cmd.write));

endmodule

`default_nettype wire

// File: rtl/write_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module write_dispatch (
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  buf_types_pkg::wr_req_t [buf_cfg_pkg::NUM_WR_PORTS-1:0] wr_req,
  input  logic                                                  read,
  input  logic                                                  rd_deq,
  input  logic [buf_cfg_pkg::ADDR_BITS-1:0]                     rd_adr,
  input  logic [buf_cfg_pkg::NUM_BANKS-1:0]                     has_free,
  input  logic [buf_cfg_pkg::NUM_BANKS-1:0][buf_cfg_pkg::ROW_BITS-1:0] free_row,
  input  logic [buf_cfg_pkg::NUM_BANKS-1:0]                     init_done,
  output buf_types_pkg::bank_cmd_t [buf_cfg_pkg::NUM_BANKS-1:0] bank_cmd,
  output logic [buf_cfg_pkg::NUM_WR_PORTS-1:0][buf_cfg_pkg::ADDR_BITS-1:0] wr_adr,
  output logic                                                  wr_bp,
  output logic                                                  ready
);

  logic [buf_cfg_pkg::BANK_BITS-1:0]    rd_bank;
  logic [buf_cfg_pkg::ROW_BITS-1:0]     rd_row;
  logic [buf_cfg_pkg::BANK_BITS:0]      n_free;
  logic [buf_cfg_pkg::NUM_BANKS-1:0]    taken;
  logic [buf_cfg_pkg::NUM_WR_PORTS-1:0] wr_want;

  assign rd_bank = rd_adr[buf_cfg_pkg::ADDR_BITS-1 -: buf_cfg_pkg::BANK_BITS];
  assign rd_row  = rd_adr[buf_cfg_pkg::ROW_BITS-1:0];

  // ****************************************
  // ready and back-pressure
  // ****************************************
  always_comb begin
    n_free = '0;
    for (int b = 0; b < buf_cfg_pkg::NUM_BANKS; b++) begin
      n_free = n_free + has_free[b];
    end
  end

  assign ready = &init_done;

  // one bank may be busy with the read and every port still needs its own bank
  assign wr_bp = !ready || (n_free < buf_cfg_pkg::NUM_WR_PORTS + 1);

  // ****************************************
  // read routing and write assignment
  // ****************************************
  always_comb begin
    logic found;
    taken  = '0;
    wr_adr = '0;
    for (int b = 0; b < buf_cfg_pkg::NUM_BANKS; b++) begin
      bank_cmd[b].read   = read && (rd_bank == buf_cfg_pkg::BANK_BITS'(b));
      bank_cmd[b].deq    = rd_deq;
      bank_cmd[b].rd_row = rd_row;
      bank_cmd[b].write  = 1'b0;
      bank_cmd[b].din    = '0;
    end
    // in port order each port takes the lowest bank still open
    for (int p = 0; p < buf_cfg_pkg::NUM_WR_PORTS; p++) begin
      found = 1'b0;
      if (wr_req[p].write && !wr_bp) begin
        for (int b = 0; b < buf_cfg_pkg::NUM_BANKS; b++) begin
          if (!found && has_free[b] && !bank_cmd[b].read && !taken[b]) begin
            found             = 1'b1;
            taken[b]          = 1'b1;
            bank_cmd[b].write = 1'b1;
            bank_cmd[b].din   = wr_req[p].din;
            wr_adr[p]         = {buf_cfg_pkg::BANK_BITS'(b), free_row[b]};
          end
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < buf_cfg_pkg::NUM_WR_PORTS; p++) begin
      wr_want[p] = wr_req[p].write;
    end
  end

  a_rd_bank_range: assert property (@(posedge clk) disable iff (rst)
    read |-> rd_bank < buf_cfg_pkg::NUM_BANKS);
  // no bank is taken under back-pressure and every write finds a bank without it
  a_no_wr_under_bp: assert property (@(posedge clk) disable iff (rst)
    $countones(taken) == (wr_bp ? 0 : $countones(wr_want)));

endmodule

`default_nettype wire

// File: rtl/read_collect.sv
`timescale 1ns/1ps
`default_nettype none

module read_collect (
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  buf_types_pkg::bank_rsp_t [buf_cfg_pkg::NUM_BANKS-1:0] rsp,
  output logic                                                  rd_vld,
  output logic [buf_cfg_pkg::DATA_WIDTH-1:0]                    rd_dout
);

  logic [buf_cfg_pkg::NUM_BANKS-1:0]   vld_vec;
  logic [buf_cfg_pkg::DATA_WIDTH-1:0]  dout_mux;

  // only the read bank answers, so an OR of gated data is enough
  always_comb begin
    dout_mux = '0;
    for (int b = 0; b < buf_cfg_pkg::NUM_BANKS; b++) begin
      vld_vec[b] = rsp[b].vld;
      if (rsp[b].vld) begin
        dout_mux = dout_mux | rsp[b].data;
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_dout <= dout_mux;
    if (rst) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= |vld_vec;
    end
  end

  a_one_rsp: assert property (@(posedge clk) disable iff (rst)
    $onehot0(vld_vec));

endmodule

`default_nettype wire

// File: rtl/mwport_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

module mwport_buffer_top (
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  buf_types_pkg::wr_req_t [buf_cfg_pkg::NUM_WR_PORTS-1:0] wr_req,
  output logic [buf_cfg_pkg::NUM_WR_PORTS-1:0][buf_cfg_pkg::ADDR_BITS-1:0] wr_adr,
  output logic                                                  wr_bp,
  input  logic                                                  read,
  input  logic                                                  rd_deq,
  input  logic [buf_cfg_pkg::ADDR_BITS-1:0]                     rd_adr,
  output logic                                                  rd_vld,
  output logic [buf_cfg_pkg::DATA_WIDTH-1:0]                    rd_dout,
  output logic                                                  ready
);

  buf_types_pkg::bank_cmd_t [buf_cfg_pkg::NUM_BANKS-1:0]        bank_cmd;
  buf_types_pkg::bank_rsp_t [buf_cfg_pkg::NUM_BANKS-1:0]        bank_rsp;
  logic [buf_cfg_pkg::NUM_BANKS-1:0]                            has_free;
  logic [buf_cfg_pkg::NUM_BANKS-1:0][buf_cfg_pkg::ROW_BITS-1:0] free_row;
  logic [buf_cfg_pkg::NUM_BANKS-1:0]                            init_done;

  write_dispatch u_dispatch (
    .clk       (clk),
    .rst       (rst),
    .wr_req    (wr_req),
    .read      (read),
    .rd_deq    (rd_deq),
    .rd_adr    (rd_adr),
    .has_free  (has_free),
    .free_row  (free_row),
    .init_done (init_done),
    .bank_cmd  (bank_cmd),
    .wr_adr    (wr_adr),
    .wr_bp     (wr_bp),
    .ready     (ready)
  );

  // ****************************************
  // bank slices
  // ****************************************
  for (genvar b = 0; b < buf_cfg_pkg::NUM_BANKS; b++) begin : g_bank
    bank_slice u_slice (
      .clk       (clk),
      .rst       (rst),
      .cmd       (bank_cmd[b]),
      .has_free  (has_free[b]),
      .free_row  (free_row[b]),
      .init_done (init_done[b]),
      .rsp       (bank_rsp[b])
    );
  end

  read_collect u_collect (
    .clk     (clk),
    .rst     (rst),
    .rsp     (bank_rsp),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  localparam int PERIOD_NS  = 20;
  localparam int RST_CYCLES = 8;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release on a falling edge, like every other input
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb/tb_mwport_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mwport_buffer;

  localparam int PORTS = buf_cfg_pkg::NUM_WR_PORTS;
  localparam int BANKS = buf_cfg_pkg::NUM_BANKS;
  localparam int ROWS  = buf_cfg_pkg::NUM_ROWS;
  localparam int BW    = buf_cfg_pkg::BANK_BITS;
  localparam int RW    = buf_cfg_pkg::ROW_BITS;
  localparam int AW    = buf_cfg_pkg::ADDR_BITS;
  localparam int DW    = buf_cfg_pkg::DATA_WIDTH;

  localparam int SEED        = 96771;
  localparam int N_MIX       = 300;
  localparam int N_B2B       = 40;
  localparam int N_FILL      = 40;
  localparam int N_DRAIN     = BANKS * ROWS;
  localparam int N_FLUSH     = 4;
  localparam int TEST_CYCLES = N_MIX + N_B2B + N_FILL + N_DRAIN + N_FLUSH;
  localparam int WATCHDOG_NS = (8 + ROWS + TEST_CYCLES * 2 + 100) * 20;

  logic                                   clk;
  logic                                   rst;
  buf_types_pkg::wr_req_t [PORTS-1:0]     wr_req;
  logic [PORTS-1:0][AW-1:0]               wr_adr;
  logic                                   wr_bp;
  logic                                   read;
  logic                                   rd_deq;
  logic [AW-1:0]                          rd_adr;
  logic                                   rd_vld;
  logic [DW-1:0]                          rd_dout;
  logic                                   ready;

  // ****************************************
  // reference model state
  // ****************************************
  // free rows per bank, top of stack at stk_cnt-1
  logic [RW-1:0]  stk_row [BANKS][ROWS];
  int             stk_cnt [BANKS];
  logic [DW-1:0]  mem_model [1 << AW];
  logic [AW-1:0]  live [$];
  int             exp_due [$];
  logic [DW-1:0]  exp_data [$];
  int             cycle;
  bit             saw_bp;
  int             adr_errs;
  int             bp_errs;
  int             rd_errs;
  int             ctrl_errs;

  tb_clock u_clock (
    .clk (clk),
    .rst (rst)
  );

  mwport_buffer_top dut (
    .clk     (clk),
    .rst     (rst),
    .wr_req  (wr_req),
    .wr_adr  (wr_adr),
    .wr_bp   (wr_bp),
    .read    (read),
    .rd_deq  (rd_deq),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .ready   (ready)
  );

  // row 0 ends on top, higher rows below it
  task automatic fill_model_stacks();
    for (int b = 0; b < BANKS; b++) begin
      for (int i = 0; i < ROWS; i++) begin
        stk_row[b][i] = RW'(ROWS - 1 - i);
      end
      stk_cnt[b] = ROWS;
    end
  endtask

  function automatic bit predict_bp();
    int n;
    n = 0;
    for (int b = 0; b < BANKS; b++) begin
      if (stk_cnt[b] > 0) n++;
    end
    return n < PORTS + 1;
  endfunction

  task automatic check_read_output();
    bit due;
    due = (exp_due.size() > 0) && (exp_due[0] == cycle);
    assert (rd_vld == due) else begin
      rd_errs++;
      $display("[ERROR] %0t: rd_vld is %b, expected %b", $time, rd_vld, due);
    end
    if (due) begin
      assert (rd_dout == exp_data[0]) else begin
        rd_errs++;
        $display("[ERROR] %0t: rd_dout is %h, expected %h", $time, rd_dout, exp_data[0]);
      end
      void'(exp_due.pop_front());
      void'(exp_data.pop_front());
    end
  endtask

  // one clock cycle of random traffic, checked and applied to the model
  task automatic run_cycle(input int wr_pct, input int rd_pct, input int deq_pct);
    bit              bp_exp;
    int              rd_bank;
    int              idx;
    int              bank;
    logic [BANKS-1:0] taken;
    logic [AW-1:0]   exp_adr;
    @(negedge clk);
    check_read_output();
    bp_exp  = predict_bp();
    saw_bp  = saw_bp | bp_exp;
    read    = 1'b0;
    rd_deq  = 1'b0;
    rd_adr  = '0;
    rd_bank = -1;
    idx     = 0;
    if (live.size() > 0 && $urandom_range(99) < rd_pct) begin
      idx     = $urandom_range(live.size() - 1);
      read    = 1'b1;
      rd_adr  = live[idx];
      rd_deq  = ($urandom_range(99) < deq_pct);
      rd_bank = int'(rd_adr[AW-1 -: BW]);
    end
    for (int p = 0; p < PORTS; p++) begin
      wr_req[p].write = !bp_exp && ($urandom_range(99) < wr_pct);
      wr_req[p].din   = $urandom();
    end
    #2;
    assert (wr_bp == bp_exp) else begin
      bp_errs++;
      $display("[ERROR] %0t: wr_bp is %b, expected %b", $time, wr_bp, bp_exp);
    end
    assert (ready == 1'b1) else begin
      ctrl_errs++;
      $display("[ERROR] %0t: ready dropped after initialization", $time);
    end
    if (read) begin
      exp_due.push_back(cycle + 2);
      exp_data.push_back(mem_model[rd_adr]);
    end
    // ports in order, each takes the lowest open bank
    taken = '0;
    for (int p = 0; p < PORTS; p++) begin
      if (wr_req[p].write) begin
        bank = -1;
        for (int b = 0; b < BANKS; b++) begin
          if (bank < 0 && b != rd_bank && !taken[b] && stk_cnt[b] > 0) bank = b;
        end
        if (bank < 0) begin
          ctrl_errs++;
          $display("model found no bank for port %0d at %0t", p, $time);
        end else begin
          exp_adr = {BW'(bank), stk_row[bank][stk_cnt[bank] - 1]};
          assert (wr_adr[p] == exp_adr) else begin
            adr_errs++;
            $display("[ERROR] %0t: wr_adr[%0d] is %h, expected %h",
                     $time, p, wr_adr[p], exp_adr);
          end
          taken[bank]        = 1'b1;
          stk_cnt[bank]      = stk_cnt[bank] - 1;
          mem_model[exp_adr] = wr_req[p].din;
          live.push_back(exp_adr);
        end
      end
    end
    if (read && rd_deq) begin
      stk_row[rd_bank][stk_cnt[rd_bank]] = rd_adr[RW-1:0];
      stk_cnt[rd_bank] = stk_cnt[rd_bank] + 1;
      live.delete(idx);
    end
    cycle++;
  endtask

  // ****************************************
  // watchdog
  // ****************************************
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // ****************************************
  // main sequence
  // ****************************************
  initial begin
    wr_req    = '0;
    read      = 1'b0;
    rd_deq    = 1'b0;
    rd_adr    = '0;
    cycle     = 0;
    saw_bp    = 1'b0;
    adr_errs  = 0;
    bp_errs   = 0;
    rd_errs   = 0;
    ctrl_errs = 0;
    void'($urandom(SEED));

    wait (rst === 1'b1);
    repeat (2) @(negedge clk);
    assert (ready === 1'b0 && rd_vld === 1'b0 && wr_bp === 1'b1) else begin
      ctrl_errs++;
      $display("[ERROR] %0t: outputs not in reset state", $time);
    end
    wait (rst === 1'b0);
    // stacks fill one row per cycle
    for (int k = 1; k <= ROWS; k++) begin
      @(negedge clk);
      assert (ready === (k == ROWS) && rd_vld === 1'b0) else begin
        ctrl_errs++;
        $display("[ERROR] %0t: ready is %b, %0d cycles after reset", $time, ready, k);
      end
      if (k < ROWS) begin
        assert (wr_bp === 1'b1) else begin
          ctrl_errs++;
          $display("[ERROR] %0t: wr_bp low before ready", $time);
        end
      end
    end
    fill_model_stacks();

    repeat (N_MIX) run_cycle(30, 70, 60);
    repeat (N_B2B) run_cycle(25, 100, 0);
    saw_bp = 1'b0;
    repeat (N_FILL) run_cycle(100, 0, 0);
    assert (saw_bp) else begin
      ctrl_errs++;
      $display("fill phase ended without write back-pressure");
    end
    for (int i = 0; i < N_DRAIN && live.size() > 0; i++) begin
      run_cycle(0, 100, 100);
    end
    repeat (N_FLUSH) run_cycle(0, 0, 0);
    assert (exp_due.size() == 0) else begin
      rd_errs++;
      $display("%0d expected read results never arrived", exp_due.size());
    end

    $display("errors: wr_adr=%0d wr_bp=%0d read=%0d control=%0d",
             adr_errs, bp_errs, rd_errs, ctrl_errs);
    if (adr_errs + bp_errs + rd_errs + ctrl_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
rtl/buf_cfg_pkg.sv
rtl/buf_types_pkg.sv
rtl/bank_sram.sv
rtl/bank_slice.sv
rtl/write_dispatch.sv
rtl/read_collect.sv
rtl/mwport_buffer_top.sv
tb/tb_clock.sv
tb/tb_mwport_buffer.sv

// File: Bender.yml
package:
  name: mwport_buffer

sources:
  - files:
      - rtl/buf_cfg_pkg.sv
      - rtl/buf_types_pkg.sv
      - rtl/bank_sram.sv
      - rtl/bank_slice.sv
      - rtl/write_dispatch.sv
      - rtl/read_collect.sv
      - rtl/mwport_buffer_top.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/tb_mwport_buffer.sv
